// File: compile.f
source/bpu_pkg.sv
source/target_table.sv
source/direction_table.sv
source/next_pc_select.sv
source/branch_predictor.sv
verification/bpu_tb.sv

// File: source/bpu_pkg.sv
package bpu_pkg;

    // pc geometry, one 32-bit word per instruction
    localparam int pc_width       = 32;
    localparam int offset_bits    = 2;                  // byte offset inside a word
    localparam int index_bits     = 8;                  // pc[9:2] picks the slot
    localparam int upper_bits     = pc_width - index_bits - offset_bits;  // pc[31:10]
    localparam int word_addr_bits = pc_width - offset_bits;               // pc[31:2]
    localparam int word_bytes     = pc_width / 8;       // sequential step, pc + 4

    // table geometry
    localparam int nr_slot = 1 << index_bits;           // 256 entries per table

    // direction counter encoding
    // 00 strong not taken, 01 weak not taken
    // 10 weak taken, 11 strong taken
    localparam int counter_bits = 2;
    localparam logic [counter_bits-1:0] counter_init = 2'b01;  // weakly not taken
    localparam logic [counter_bits-1:0] counter_max  = 2'b11;  // saturate taken side
    localparam logic [counter_bits-1:0] counter_min  = 2'b00;  // saturate not-taken side

    // one pc word with two readings
    // word is the plain byte address, used for pc + 4
    // fields splits it into tag-less upper part, slot index and byte offset
    typedef union packed {
        logic [pc_width-1:0] word;
        struct packed {
            logic [upper_bits-1:0]  upper;   // pc[31:10], ignored by lookup
            logic [index_bits-1:0]  index;   // pc[9:2]
            logic [offset_bits-1:0] offset;  // pc[1:0], zero for aligned fetch
        } fields;
    } pc_addr_t;

endpackage

// File: source/branch_predictor.sv
`timescale 1ns/1ps

// fetch-stage next-pc predictor
// target table and direction table are looked up in parallel from current_pc
// both are trained in parallel from the resolve strobe
module branch_predictor import bpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    // fetch side
    input  pc_addr_t current_pc,     // pc being fetched this cycle
    output pc_addr_t predicted_pc,   // next fetch pc, same cycle
    output logic     predict_taken,  // prediction redirects fetch
    // resolve side, from a later pipeline stage
    input  logic     update_en,      // one-cycle strobe per resolved branch
    input  pc_addr_t update_pc,      // pc of the resolved branch
    input  logic     update_taken,   // actual direction
    input  pc_addr_t update_target   // actual target
);

    // lookup results
    logic     target_valid;  // slot holds a target
    pc_addr_t target_pc;     // stored target
    logic     dir_taken;     // counter says taken

    // target store with hysteresis replacement
    target_table u_target_table (
        .clk           (clk),
        .reset         (reset),
        .current_pc    (current_pc),
        .update_en     (update_en),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target),
        .target_valid  (target_valid),
        .target_pc     (target_pc)
    );

    // 2-bit direction counters, no target needed
    direction_table u_direction_table (
        .clk          (clk),
        .reset        (reset),
        .current_pc   (current_pc),
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .dir_taken    (dir_taken)
    );

    // final pick between target and pc + 4
    next_pc_select u_next_pc_select (
        .current_pc    (current_pc),
        .target_valid  (target_valid),
        .target_pc     (target_pc),
        .dir_taken     (dir_taken),
        .predicted_pc  (predicted_pc),
        .predict_taken (predict_taken)
    );

endmodule

// File: source/direction_table.sv
`timescale 1ns/1ps

// direct-mapped table of 2-bit saturating direction counters
// same pc[9:2] index as the target table
module direction_table import bpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pc_addr_t current_pc,    // fetch pc being looked up
    input  logic     update_en,     // one strobe per resolved branch
    input  pc_addr_t update_pc,     // pc of the resolved branch
    input  logic     update_taken,  // outcome moves the counter up or down
    output logic     dir_taken      // msb of the indexed counter
);

    logic [counter_bits-1:0] counters [nr_slot];  // one counter per slot

    // lookup side
    logic [index_bits-1:0]   rd_idx;
    logic [counter_bits-1:0] rd_count;

    // update side
    logic [index_bits-1:0]   upd_idx;
    logic [counter_bits-1:0] cur_count;   // counter before this update
    logic [counter_bits-1:0] next_count;  // counter after saturation

    // combinational read, old value until the next edge
    assign rd_idx    = current_pc.fields.index;
    assign rd_count  = counters[rd_idx];
    assign dir_taken = rd_count[counter_bits-1];  // 10 and 11 predict taken

    assign upd_idx   = update_pc.fields.index;
    assign cur_count = counters[upd_idx];

    // saturating step
    always_comb begin
        next_count = cur_count;
        if (update_taken) begin
            if (cur_count != counter_max) begin
                next_count = cur_count + counter_bits'(1);  // towards strong taken
            end
        end else begin
            if (cur_count != counter_min) begin
                next_count = cur_count - counter_bits'(1);  // towards strong not taken
            end
        end
    end

    // all counters start weakly not taken
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < nr_slot; i++) begin
                counters[i] <= counter_init;
            end
        end else if (update_en) begin
            counters[upd_idx] <= next_count;  // every resolved branch trains, taken or not
        end
    end

endmodule

// File: source/next_pc_select.sv
`timescale 1ns/1ps

// merges target lookup and direction lookup into the fetch prediction
// purely combinational, same cycle as current_pc
module next_pc_select import bpu_pkg::*; (
    input  pc_addr_t current_pc,    // pc being fetched
    input  logic     target_valid,  // target table slot allocated
    input  pc_addr_t target_pc,     // stored target, word aligned
    input  logic     dir_taken,     // counter msb from the direction table
    output pc_addr_t predicted_pc,  // next fetch address
    output logic     predict_taken  // redirect to target_pc
);

    pc_addr_t seq_pc;  // fall-through address

    // a target alone is not enough
    // the counter has to agree before fetch is redirected
    assign predict_taken = target_valid & dir_taken;

    // sequential path works on the whole word, carries into the upper bits
    assign seq_pc.word = current_pc.word + pc_width'(word_bytes);  // pc + 4, no delay slot

    // redirect or fall through
    assign predicted_pc = predict_taken ? target_pc : seq_pc;

endmodule

// File: source/target_table.sv
`timescale 1ns/1ps

// direct-mapped branch target store
// no tag compare
// pcs that share pc[9:2] alias onto one slot
module target_table import bpu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  pc_addr_t current_pc,     // fetch pc being looked up
    input  logic     update_en,      // one strobe per resolved branch
    input  pc_addr_t update_pc,      // pc of the resolved branch
    input  logic     update_taken,   // branch outcome
    input  pc_addr_t update_target,  // resolved target address
    output logic     target_valid,   // slot holds a target
    output pc_addr_t target_pc       // stored target, low bits zero
);

    // per-slot storage
    logic [word_addr_bits-1:0] target_mem [nr_slot];  // target word address pc[31:2]
    logic [nr_slot-1:0]        valid_bits;            // set once and cleared only by reset
    logic [nr_slot-1:0]        hyst_bits;             // one-miss tolerance before replace

    // lookup side
    logic [index_bits-1:0] rd_idx;

    // update side
    logic [index_bits-1:0]     upd_idx;
    logic [word_addr_bits-1:0] upd_word;      // new target as word address
    logic                      upd_valid;     // current state of the updated slot
    logic                      upd_hyst;
    logic                      upd_match;     // stored target equals resolved one
    logic                      taken_strobe;  // only taken branches train this table
    logic                      write_target;
    logic                      next_hyst;

    // combinational read sees state as of the last edge
    assign rd_idx       = current_pc.fields.index;
    assign target_valid = valid_bits[rd_idx];
    assign target_pc.word = {target_mem[rd_idx], {offset_bits{1'b0}}};  // re-append byte offset

    // decode the update request
    assign upd_idx      = update_pc.fields.index;
    assign upd_word     = {update_target.fields.upper, update_target.fields.index};
    assign upd_valid    = valid_bits[upd_idx];
    assign upd_hyst     = hyst_bits[upd_idx];
    assign upd_match    = (target_mem[upd_idx] == upd_word);
    assign taken_strobe = update_en & update_taken;  // not-taken leaves slot untouched

    // replacement rule
    always_comb begin
        write_target = 1'b0;
        next_hyst    = upd_hyst;
        if (!upd_valid) begin
            // empty slot is allocated straight away
            write_target = 1'b1;
            next_hyst    = 1'b0;
        end else if (upd_match) begin
            next_hyst = 1'b1;      // confirmed target arms hysteresis
        end else if (upd_hyst) begin
            next_hyst = 1'b0;      // first miss only spends the spare chance
        end else begin
            // second miss in a row replaces the target
            write_target = 1'b1;
            next_hyst    = 1'b0;
        end
    end

    // valid and hysteresis bits
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            hyst_bits  <= '0;
        end else if (taken_strobe) begin
            valid_bits[upd_idx] <= 1'b1;       // any taken update leaves slot valid
            hyst_bits[upd_idx]  <= next_hyst;
        end
    end

    // target payload
    always_ff @(posedge clk) begin
        if (taken_strobe && write_target) begin
            target_mem[upd_idx] <= upd_word;
        end
    end

endmodule

// File: verification/bpu_tb.sv
`timescale 1ns/1ps

// directed and random checks of the fetch-stage next-pc predictor
// a small reference model tracks valid, hysteresis, target and counter per slot
module bpu_tb import bpu_pkg::*; ();

    localparam int          clk_half     = 10;          // 20 ns period
    localparam int          reset_cycles = 16;
    localparam int          settle_limit = 8;           // cycles allowed for outputs after reset
    localparam int          random_steps = 300;
    localparam logic [31:0] rng_seed     = 32'd35326;

    // dut side
    logic        clk;
    logic        reset;
    logic [31:0] current_pc;
    logic        update_en;
    logic [31:0] update_pc;
    logic        update_taken;
    logic [31:0] update_target;
    logic [31:0] predicted_pc;
    logic        predict_taken;

    // reference model, one entry per slot
    logic        ref_valid  [nr_slot];
    logic        ref_hyst   [nr_slot];
    logic [31:0] ref_target [nr_slot];  // byte address, low two bits zero
    logic [1:0]  ref_count  [nr_slot];  // 2-bit saturating counter

    int          error_count;
    int          check_count;
    logic [31:0] rng_state;

    // random traffic pools, some pcs share a slot on purpose
    logic [31:0] pc_pool     [8];
    logic [31:0] target_pool [4];

    branch_predictor u_dut (
        .clk           (clk),
        .reset         (reset),
        .current_pc    (current_pc),
        .predicted_pc  (predicted_pc),
        .predict_taken (predict_taken),
        .update_en     (update_en),
        .update_pc     (update_pc),
        .update_taken  (update_taken),
        .update_target (update_target)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // slot index is pc[9:2], no tag
    function automatic int slot_of(input logic [31:0] pc);
        return int'(pc[9:2]);
    endfunction

    // taken only when the slot holds a target and the counter msb is set
    function automatic logic expected_taken(input logic [31:0] pc);
        int idx;
        idx = slot_of(pc);
        return ref_valid[idx] && ref_count[idx][1];
    endfunction

    function automatic logic [31:0] expected_next_pc(input logic [31:0] pc);
        int idx;
        idx = slot_of(pc);
        if (ref_valid[idx] && ref_count[idx][1]) begin
            return ref_target[idx];
        end
        return pc + 32'd4;  // fall through, no delay slot
    endfunction

    task automatic clear_model();
        for (int i = 0; i < nr_slot; i++) begin
            ref_valid[i]  = 1'b0;
            ref_hyst[i]   = 1'b0;
            ref_target[i] = 32'h0;
            ref_count[i]  = counter_init;  // weakly not taken
        end
    endtask

    // one resolved branch applied to the model
    task automatic train_model(input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        int          idx;
        logic [31:0] aligned;
        idx     = slot_of(pc);
        aligned = {target[31:2], 2'b00};  // only the word address is kept
        if (taken) begin
            if (ref_count[idx] != 2'b11) begin
                ref_count[idx] = ref_count[idx] + 2'd1;
            end
            if (!ref_valid[idx]) begin
                ref_target[idx] = aligned;  // first allocation
                ref_valid[idx]  = 1'b1;
                ref_hyst[idx]   = 1'b0;
            end else if (ref_target[idx] == aligned) begin
                ref_hyst[idx] = 1'b1;       // confirmed
            end else if (ref_hyst[idx]) begin
                ref_hyst[idx] = 1'b0;       // spare chance used, target kept
            end else begin
                ref_target[idx] = aligned;  // second miss replaces
                ref_hyst[idx]   = 1'b0;
            end
        end else if (ref_count[idx] != 2'b00) begin
            ref_count[idx] = ref_count[idx] - 2'd1;  // not taken touches the counter only
        end
    endtask

    task automatic check_outputs(input logic [31:0] pc, input logic exp_taken,
                                 input logic [31:0] exp_pc);
        check_count++;
        if (predict_taken !== exp_taken) begin
            error_count++;
            $display("[ERROR] predict_taken for pc %h: expected %h, actual %h",
                     pc, exp_taken, predict_taken);
        end
        check_count++;
        if (predicted_pc !== exp_pc) begin
            error_count++;
            $display("[ERROR] predicted_pc for pc %h: expected %h, actual %h",
                     pc, exp_pc, predicted_pc);
        end
    endtask

    task automatic compare_with_model(input logic [31:0] pc);
        check_outputs(pc, expected_taken(pc), expected_next_pc(pc));
    endtask

    // one clock cycle with an optional update and a lookup
    // the lookup is checked before the edge, so it must see the old state
    task automatic drive_cycle(input logic en, input logic [31:0] u_pc, input logic u_taken,
                               input logic [31:0] u_target, input logic [31:0] look_pc);
        @(negedge clk);
        update_en     = en;
        update_pc     = u_pc;
        update_taken  = u_taken;
        update_target = u_target;
        current_pc    = look_pc;
        #2;
        compare_with_model(look_pc);
        @(posedge clk);
        if (en) begin
            train_model(u_pc, u_taken, u_target);  // dut takes it on this edge too
        end
    endtask

    task automatic train(input logic [31:0] pc, input logic taken, input logic [31:0] target);
        drive_cycle(1'b1, pc, taken, target, pc);
    endtask

    // lookup with no update, checked against given values and the model
    task automatic expect_lookup(input logic [31:0] pc, input logic exp_taken,
                                 input logic [31:0] exp_pc);
        @(negedge clk);
        update_en  = 1'b0;
        current_pc = pc;
        #2;
        check_outputs(pc, exp_taken, exp_pc);
        compare_with_model(pc);
    endtask

    // outputs must show the cleared state shortly after reset drops
    task automatic wait_reset_clear();
        int   waited;
        logic settled;
        waited  = 0;
        settled = 1'b0;
        while (!settled && waited < settle_limit) begin
            @(negedge clk);
            #2;
            settled = (predict_taken === 1'b0) && (predicted_pc === current_pc + 32'd4);
            waited++;
        end
        if (!settled) begin
            $display("timeout: predictor outputs never showed the reset state");
            $display(">>> FAIL");
            $finish;
        end
    endtask

    // every slot once, plus a pc whose +4 wraps
    task automatic reset_sweep();
        logic [31:0] pc;
        for (int i = 0; i < nr_slot; i++) begin
            pc = 32'h0040_0000 + 32'(i * 4);
            expect_lookup(pc, 1'b0, pc + 32'd4);
        end
        expect_lookup(32'hbfc0_0ffc, 1'b0, 32'hbfc0_1000);  // carry past the index bits
        expect_lookup(32'hffff_fffc, 1'b0, 32'h0000_0000);  // wraps to zero
    endtask

    // 01 -> 10 and valid set by one taken update
    task automatic single_taken_update();
        logic [31:0] pc;
        logic [31:0] tgt;
        pc  = 32'h0040_0100;
        tgt = 32'h0040_0800;
        expect_lookup(pc, 1'b0, pc + 32'd4);
        train(pc, 1'b1, tgt);
        expect_lookup(pc, 1'b1, tgt);
        expect_lookup(pc + 32'd4, 1'b0, pc + 32'd8);  // neighbour slot untouched
    endtask

    // same slot as above, counter starts at 10
    task automatic not_taken_keeps_target();
        logic [31:0] pc;
        logic [31:0] tgt;
        pc  = 32'h0040_0100;
        tgt = 32'h0040_0800;
        train(pc, 1'b0, tgt);                  // 10 -> 01
        expect_lookup(pc, 1'b0, pc + 32'd4);
        train(pc, 1'b0, tgt);                  // 01 -> 00
        expect_lookup(pc, 1'b0, pc + 32'd4);
        train(pc, 1'b1, tgt);                  // 00 -> 01, still below taken
        expect_lookup(pc, 1'b0, pc + 32'd4);
        train(pc, 1'b1, tgt);                  // 01 -> 10
        expect_lookup(pc, 1'b1, tgt);          // old target was never lost
    endtask

    // one wrong target is tolerated, the second one replaces
    task automatic hysteresis_replace();
        logic [31:0] pc;
        logic [31:0] tgt_a;
        logic [31:0] tgt_b;
        logic [31:0] tgt_c;
        pc    = 32'h0040_0300;
        tgt_a = 32'h0040_1000;
        tgt_b = 32'h0040_2000;
        tgt_c = 32'h0040_3002;                 // misaligned on purpose
        train(pc, 1'b1, tgt_a);                // allocate, hyst 0
        train(pc, 1'b1, tgt_a);                // match, hyst 1
        expect_lookup(pc, 1'b1, tgt_a);
        train(pc, 1'b1, tgt_b);                // first miss clears hyst
        expect_lookup(pc, 1'b1, tgt_a);
        train(pc, 1'b1, tgt_b);                // second miss
        expect_lookup(pc, 1'b1, tgt_b);
        train(pc, 1'b1, tgt_c);                // hyst already 0, replaced at once
        expect_lookup(pc, 1'b1, 32'h0040_3000);  // byte offset dropped
    endtask

    // pcs equal in bits 9:2 share one slot
    task automatic index_aliasing();
        logic [31:0] pc_one;
        logic [31:0] pc_two;
        logic [31:0] tgt;
        pc_one = 32'h0040_0200;
        pc_two = 32'h1234_0200;
        tgt    = 32'h0040_5000;
        expect_lookup(pc_two, 1'b0, pc_two + 32'd4);
        train(pc_one, 1'b1, tgt);
        expect_lookup(pc_two, 1'b1, tgt);      // alias sees the other branch's target
        expect_lookup(pc_one, 1'b1, tgt);
        train(pc_two, 1'b0, tgt);              // 10 -> 01 through the alias
        expect_lookup(pc_one, 1'b0, pc_one + 32'd4);
    endtask

    // mixed updates and lookups, model compared every cycle
    task automatic random_traffic();
        logic        en;
        logic [31:0] u_pc;
        logic        u_taken;
        logic [31:0] u_target;
        logic [31:0] look_pc;
        for (int i = 0; i < random_steps; i++) begin
            rng_state = xorshift32(rng_state);
            en        = rng_state[0] | rng_state[1];    // about three updates in four cycles
            u_pc      = pc_pool[rng_state[4:2]];
            u_taken   = rng_state[5] | rng_state[6];    // biased towards taken
            u_target  = target_pool[rng_state[8:7]];
            look_pc   = pc_pool[rng_state[11:9]];
            drive_cycle(en, u_pc, u_taken, u_target, look_pc);
        end
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b0, 32'h0, 1'b0, 32'h0, pc_pool[i]);  // final state of the pool
        end
    endtask

    initial begin
        error_count   = 0;
        check_count   = 0;
        rng_state     = rng_seed;
        reset         = 1'b1;
        current_pc    = 32'h0040_0000;
        update_en     = 1'b0;
        update_pc     = 32'h0;
        update_taken  = 1'b0;
        update_target = 32'h0;
        clear_model();

        pc_pool[0] = 32'h0040_0000;
        pc_pool[1] = 32'h0040_0004;
        pc_pool[2] = 32'h0040_0010;
        pc_pool[3] = 32'h0040_1010;  // alias of pool entry 2
        pc_pool[4] = 32'h0040_0ff8;
        pc_pool[5] = 32'h7fff_0ff8;  // alias of pool entry 4
        pc_pool[6] = 32'h0040_0040;
        pc_pool[7] = 32'h0040_0044;
        target_pool[0] = 32'h0040_2000;
        target_pool[1] = 32'h0040_3004;
        target_pool[2] = 32'h8000_0180;
        target_pool[3] = 32'h0040_400b;  // low bits must vanish

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_reset_clear();

        reset_sweep();
        single_taken_update();
        not_taken_keeps_target();
        hysteresis_replace();
        index_aliasing();
        random_traffic();

        @(negedge clk);
        update_en = 1'b0;

        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
